//--- tests/decoder_patterns.txt
# per slot: valid pc inst pre_is_branch pre_taken pre_branch_addr fetch_exc fetch_ecode, then flush pause invalid_en
# then per slot expected: uop rd rj rk imm reg_write ecode (all hex)
1 1c000000 00100c41 0 0 00000000 0 00 1 1c000004 001118a4 0 0 00000000 0 00 0 0 0 00 01 02 03 00000000 1 00 01 04 05 06 00000000 1 00
1 1c000008 00122507 0 0 00000000 0 00 1 1c00000c 00148820 0 0 00000000 0 00 0 0 0 05 07 08 09 00000000 1 00 02 00 01 02 00000000 0 00
1 1c000010 0015316a 0 0 00000000 0 00 1 1c000014 0015bdcd 0 0 00000000 0 00 0 0 0 03 0a 0b 0c 00000000 1 00 04 0d 0e 0f 00000000 1 00
1 1c000018 02bffc41 0 0 00000000 0 00 1 1c00001c 03600083 0 0 00000000 0 00 0 0 0 06 01 02 00 ffffffff 1 00 07 03 04 00 00000800 1 00
1 1c000020 03aaf0c5 0 0 00000000 0 00 1 1c000024 142468a7 0 0 00000000 0 00 0 0 0 08 05 06 00 00000abc 1 00 09 07 00 00 12345000 1 00
1 1c000028 5bfff022 1 1 1c000018 0 00 1 1c00002c 5c002064 1 0 1c00004c 0 00 0 0 0 0a 02 01 02 fffffff0 0 00 0b 04 03 04 00000020 0 00
1 1c000030 002b0005 0 0 00000000 0 00 1 1c000034 002a0000 0 0 00000000 0 00 0 0 0 0c 00 00 00 00000000 0 0b 0d 00 00 00 00000000 0 0c
1 1c000038 ffffffff 0 0 00000000 0 00 1 1c00003c 00000000 0 0 00000000 0 00 0 0 0 0e 00 00 00 00000000 0 0d 0e 00 00 00 00000000 0 0d
1 1c000040 ffffffff 0 0 00000000 1 08 1 1c000044 002b0005 0 0 00000000 1 08 0 0 0 0e 00 00 00 00000000 0 08 0c 00 00 00 00000000 0 08
0 00000000 00000000 0 0 00000000 0 00 1 1c000048 00100c41 0 0 00000000 0 00 0 0 0 00 00 00 00 00000000 0 00 00 01 02 03 00000000 1 00
1 1c00004c 001118a4 0 0 00000000 0 00 0 00000000 00000000 0 0 00000000 0 00 0 0 0 01 04 05 06 00000000 1 00 00 00 00 00 00000000 0 00
1 1c000050 00100c41 0 0 00000000 0 00 1 1c000054 001118a4 0 0 00000000 0 00 0 0 2 00 01 02 03 00000000 1 00 01 04 05 06 00000000 1 00
1 1c000058 00122507 0 0 00000000 0 00 1 1c00005c 0015316a 0 0 00000000 0 00 0 0 3 05 07 08 09 00000000 1 00 03 0a 0b 0c 00000000 1 00
1 1c000060 0015bdcd 0 0 00000000 0 00 1 1c000064 03aaf0c5 0 0 00000000 0 00 0 1 0 04 0d 0e 0f 00000000 1 00 08 05 06 00 00000abc 1 00
1 1c000068 02bffc41 0 0 00000000 0 00 1 1c00006c 03600083 0 0 00000000 0 00 0 1 0 06 01 02 00 ffffffff 1 00 07 03 04 00 00000800 1 00
1 1c000070 0015316a 0 0 00000000 0 00 1 1c000074 0015bdcd 0 0 00000000 0 00 0 1 0 03 0a 0b 0c 00000000 1 00 04 0d 0e 0f 00000000 1 00
1 1c000078 00100c41 0 0 00000000 0 00 1 1c00007c 001118a4 0 0 00000000 0 00 0 1 0 00 01 02 03 00000000 1 00 01 04 05 06 00000000 1 00
1 1c000080 00122507 0 0 00000000 0 00 1 1c000084 03aaf0c5 0 0 00000000 0 00 0 1 0 05 07 08 09 00000000 1 00 08 05 06 00 00000abc 1 00
1 1c000088 02bffc41 0 0 00000000 0 00 1 1c00008c 03600083 0 0 00000000 0 00 0 1 0 06 01 02 00 ffffffff 1 00 07 03 04 00 00000800 1 00
1 1c000090 00100c41 0 0 00000000 0 00 1 1c000094 001118a4 0 0 00000000 0 00 1 1 0 00 01 02 03 00000000 1 00 01 04 05 06 00000000 1 00
1 1c000098 0015316a 0 0 00000000 0 00 1 1c00009c 0015bdcd 0 0 00000000 0 00 0 0 0 03 0a 0b 0c 00000000 1 00 04 0d 0e 0f 00000000 1 00
1 1c0000a0 06488000 0 0 00000000 0 00 1 1c0000a4 00100c41 0 0 00000000 0 00 0 0 0 0e 00 00 00 00000000 0 00 00 01 02 03 00000000 1 00

//--- decoder.f
logic/pipeline_pkg.sv
logic/loongarch_isa_pkg.sv
logic/id.sv
logic/issue_queue.sv
logic/decoder.sv
tests/decoder_props.sv
tests/decoder_checker.sv
tests/decoder_tb.sv

//--- tests/decoder_tb.sv
`timescale 1ns/1ps

module decoder_tb
    import pipeline_pkg::*;
();

    localparam int FIELDS = 33;  // tokens per pattern line

    logic                     clk;
    logic                     reset;
    logic                     flush;
    logic                     pause;
    logic [DECODER_WIDTH-1:0] inst_valid;
    bus32_t                   pc[DECODER_WIDTH];
    bus32_t                   inst[DECODER_WIDTH];
    logic [DECODER_WIDTH-1:0] pre_is_branch;
    logic [DECODER_WIDTH-1:0] pre_taken;
    bus32_t                   pre_branch_addr[DECODER_WIDTH];
    logic [DECODER_WIDTH-1:0] fetch_exc;
    logic [ECODE_WIDTH-1:0]   fetch_ecode[DECODER_WIDTH];
    logic [ISSUE_WIDTH-1:0]   invalid_en;

    logic                     pause_decoder;
    logic [ISSUE_WIDTH-1:0]   dispatch_valid;
    bus32_t                   dispatch_pc[ISSUE_WIDTH];
    logic [UOP_WIDTH-1:0]     dispatch_uop[ISSUE_WIDTH];
    logic [REG_IDX_WIDTH-1:0] dispatch_rd[ISSUE_WIDTH];
    logic [REG_IDX_WIDTH-1:0] dispatch_rj[ISSUE_WIDTH];
    logic [REG_IDX_WIDTH-1:0] dispatch_rk[ISSUE_WIDTH];
    bus32_t                   dispatch_imm[ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0]   dispatch_reg_write;
    logic [ISSUE_WIDTH-1:0]   dispatch_pre_is_branch;
    logic [ISSUE_WIDTH-1:0]   dispatch_pre_taken;
    bus32_t                   dispatch_pre_branch_addr[ISSUE_WIDTH];
    logic [ECODE_WIDTH-1:0]   dispatch_ecode[ISSUE_WIDTH];

    logic [UOP_WIDTH-1:0]     exp_uop[DECODER_WIDTH];
    logic [REG_IDX_WIDTH-1:0] exp_rd[DECODER_WIDTH];
    logic [REG_IDX_WIDTH-1:0] exp_rj[DECODER_WIDTH];
    logic [REG_IDX_WIDTH-1:0] exp_rk[DECODER_WIDTH];
    bus32_t                   exp_imm[DECODER_WIDTH];
    logic [DECODER_WIDTH-1:0] exp_reg_write;
    logic [ECODE_WIDTH-1:0]   exp_ecode[DECODER_WIDTH];

    int                       error_count;
    logic                     accepted;
    logic                     queue_empty;

    logic [31:0]              fields[$];
    int                       line_count;
    int                       pattern_errors;
    int                       assert_errors;
    int                       cycles;
    int                       cycle_limit = 1000;

    decoder decoder_inst (.*);
    decoder_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic read_patterns();
        int    fd;
        int    n;
        string text;
        string tok;
        fd = $fopen("tests/decoder_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/decoder_patterns.txt");
            pattern_errors++;
            return;
        end
        while ($fgets(text, fd) > 0) begin
            if (text[0] == "#") continue;
            n    = 0;
            tok  = "";
            text = {text, " "};
            for (int c = 0; c < text.len(); c++) begin
                if (text[c] == " " || text[c] == "\t" || text[c] == "\n" || text[c] == "\r") begin
                    if (tok.len() > 0) begin
                        fields.push_back(tok.atohex());
                        n++;
                    end
                    tok = "";
                end else begin
                    tok = {tok, text.substr(c, c)};
                end
            end
            if (n == FIELDS) begin
                line_count++;
            end else if (n != 0) begin
                $display("pattern line with %0d fields instead of %0d skipped", n, FIELDS);
                pattern_errors++;
                repeat (n) void'(fields.pop_back());
            end
        end
        $fclose(fd);
    endtask

    // hold drops pause and invalid_en so a full queue can drain
    task automatic apply_line(input int k, input bit hold);
        int b;
        b = k * FIELDS;
        for (int s = 0; s < DECODER_WIDTH; s++) begin
            inst_valid[s]      = fields[b + 8 * s][0];
            pc[s]              = fields[b + 8 * s + 1];
            inst[s]            = fields[b + 8 * s + 2];
            pre_is_branch[s]   = fields[b + 8 * s + 3][0];
            pre_taken[s]       = fields[b + 8 * s + 4][0];
            pre_branch_addr[s] = fields[b + 8 * s + 5];
            fetch_exc[s]       = fields[b + 8 * s + 6][0];
            fetch_ecode[s]     = fields[b + 8 * s + 7][ECODE_WIDTH-1:0];
            exp_uop[s]         = fields[b + 19 + 7 * s][UOP_WIDTH-1:0];
            exp_rd[s]          = fields[b + 20 + 7 * s][REG_IDX_WIDTH-1:0];
            exp_rj[s]          = fields[b + 21 + 7 * s][REG_IDX_WIDTH-1:0];
            exp_rk[s]          = fields[b + 22 + 7 * s][REG_IDX_WIDTH-1:0];
            exp_imm[s]         = fields[b + 23 + 7 * s];
            exp_reg_write[s]   = fields[b + 24 + 7 * s][0];
            exp_ecode[s]       = fields[b + 25 + 7 * s][ECODE_WIDTH-1:0];
        end
        flush      = fields[b + 16][0];
        pause      = hold ? 1'b0 : fields[b + 17][0];
        invalid_en = hold ? '0 : fields[b + 18][ISSUE_WIDTH-1:0];
    endtask

    initial begin
        int gap;
        void'($urandom(32'hddff));
        reset         = 1'b1;
        flush         = 1'b0;
        pause         = 1'b0;
        inst_valid    = '0;
        pre_is_branch = '0;
        pre_taken     = '0;
        fetch_exc     = '0;
        invalid_en    = '0;
        exp_reg_write = '0;
        for (int s = 0; s < DECODER_WIDTH; s++) begin
            pc[s]              = '0;
            inst[s]            = '0;
            pre_branch_addr[s] = '0;
            fetch_ecode[s]     = '0;
            exp_uop[s]         = '0;
            exp_rd[s]          = '0;
            exp_rj[s]          = '0;
            exp_rk[s]          = '0;
            exp_imm[s]         = '0;
            exp_ecode[s]       = '0;
        end
        read_patterns();
        cycle_limit = 4 * line_count + 100;
        repeat (10) @(posedge clk);
        #2 reset = 1'b0;

        for (int k = 0; k < line_count; k++) begin
            @(posedge clk);
            #2 apply_line(k, 1'b0);
            @(negedge clk);
            #1;
            while (pause_decoder && !accepted && !flush) begin  // front end holds the pair
                @(posedge clk);
                #2 apply_line(k, 1'b1);
                @(negedge clk);
                #1;
            end
            gap = $urandom_range(2, 0);
            repeat (gap) begin
                @(posedge clk);
                #2 inst_valid = '0;
                flush = 1'b0;
            end
        end

        @(posedge clk);
        #2 inst_valid = '0;
        flush      = 1'b0;
        pause      = 1'b0;
        invalid_en = '0;
        @(negedge clk);
        #1;
        while (!queue_empty) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);

        assert_errors = decoder_inst.u_decoder_props.fail_count;
        $display("run finished with %0d check errors, %0d assertion failures, %0d pattern errors",
                 error_count, assert_errors, pattern_errors);
        if (error_count == 0 && assert_errors == 0 && pattern_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/decoder_checker.sv
`timescale 1ns/1ps

module decoder_checker
    import pipeline_pkg::*;
    import loongarch_isa_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     pause,
    input  logic [DECODER_WIDTH-1:0] inst_valid,
    input  bus32_t                   pc[DECODER_WIDTH],
    input  bus32_t                   inst[DECODER_WIDTH],
    input  logic [DECODER_WIDTH-1:0] pre_is_branch,
    input  logic [DECODER_WIDTH-1:0] pre_taken,
    input  bus32_t                   pre_branch_addr[DECODER_WIDTH],
    input  logic [ISSUE_WIDTH-1:0]   invalid_en,
    input  logic [UOP_WIDTH-1:0]     exp_uop[DECODER_WIDTH],
    input  logic [REG_IDX_WIDTH-1:0] exp_rd[DECODER_WIDTH],
    input  logic [REG_IDX_WIDTH-1:0] exp_rj[DECODER_WIDTH],
    input  logic [REG_IDX_WIDTH-1:0] exp_rk[DECODER_WIDTH],
    input  bus32_t                   exp_imm[DECODER_WIDTH],
    input  logic [DECODER_WIDTH-1:0] exp_reg_write,
    input  logic [ECODE_WIDTH-1:0]   exp_ecode[DECODER_WIDTH],
    input  logic                     pause_decoder,
    input  logic [ISSUE_WIDTH-1:0]   dispatch_valid,
    input  bus32_t                   dispatch_pc[ISSUE_WIDTH],
    input  logic [UOP_WIDTH-1:0]     dispatch_uop[ISSUE_WIDTH],
    input  logic [REG_IDX_WIDTH-1:0] dispatch_rd[ISSUE_WIDTH],
    input  logic [REG_IDX_WIDTH-1:0] dispatch_rj[ISSUE_WIDTH],
    input  logic [REG_IDX_WIDTH-1:0] dispatch_rk[ISSUE_WIDTH],
    input  bus32_t                   dispatch_imm[ISSUE_WIDTH],
    input  logic [ISSUE_WIDTH-1:0]   dispatch_reg_write,
    input  logic [ISSUE_WIDTH-1:0]   dispatch_pre_is_branch,
    input  logic [ISSUE_WIDTH-1:0]   dispatch_pre_taken,
    input  bus32_t                   dispatch_pre_branch_addr[ISSUE_WIDTH],
    input  logic [ECODE_WIDTH-1:0]   dispatch_ecode[ISSUE_WIDTH],
    output int                       error_count,
    output logic                     accepted,
    output logic                     queue_empty
);

    typedef struct {
        bus32_t                   pc;
        logic [UOP_WIDTH-1:0]     uop;
        logic [REG_IDX_WIDTH-1:0] rd;
        logic [REG_IDX_WIDTH-1:0] rj;
        logic [REG_IDX_WIDTH-1:0] rk;
        bus32_t                   imm;
        logic                     reg_write;
        logic                     pre_is_branch;
        logic                     pre_taken;
        bus32_t                   pre_branch_addr;
        logic [ECODE_WIDTH-1:0]   ecode;
    } entry_t;

    entry_t model[$];  // expected queue contents, oldest first
    entry_t e;
    logic   take0;
    logic   take1;
    logic   idle_seen;
    logic   model_full;

    initial begin
        error_count = 0;
        accepted    = 1'b0;
        queue_empty = 1'b1;
    end

    task automatic check_field(input string name, input int slot, input logic [31:0] want,
                               input logic [31:0] got);
        if (want !== got) begin
            error_count++;
            $display("[ERROR] %0t: slot %0d %s expected %h, got %h", $time, slot, name, want, got);
        end
    endtask

    task automatic compare_slot(input int j);
        entry_t want;
        want = model.pop_front();
        check_field("pc", j, want.pc, dispatch_pc[j]);
        check_field("uop", j, want.uop, dispatch_uop[j]);
        check_field("rd", j, want.rd, dispatch_rd[j]);
        check_field("rj", j, want.rj, dispatch_rj[j]);
        check_field("rk", j, want.rk, dispatch_rk[j]);
        check_field("imm", j, want.imm, dispatch_imm[j]);
        check_field("reg_write", j, want.reg_write, dispatch_reg_write[j]);
        check_field("pre_is_branch", j, want.pre_is_branch, dispatch_pre_is_branch[j]);
        check_field("pre_taken", j, want.pre_taken, dispatch_pre_taken[j]);
        check_field("pre_branch_addr", j, want.pre_branch_addr, dispatch_pre_branch_addr[j]);
        check_field("ecode", j, want.ecode, dispatch_ecode[j]);
    endtask

    // evaluated mid-cycle for the coming rising edge
    always @(negedge clk) begin
        if (reset) begin
            model.delete();
            accepted = 1'b0;
        end else begin
            model_full = model.size() > ISSUE_QUEUE_DEPTH - DECODER_WIDTH;
            idle_seen  = 1'b0;
            for (int s = 0; s < DECODER_WIDTH; s++) begin
                if (inst_valid[s] && inst[s][31:15] == IDLE) idle_seen = 1'b1;
            end
            if (dispatch_valid !== {model.size() > 1, model.size() > 0}) begin
                error_count++;
                $display("[ERROR] %0t: dispatch_valid %b with %0d entries queued",
                         $time, dispatch_valid, model.size());
            end
            if (pause_decoder !== (model_full || idle_seen)) begin
                error_count++;
                $display("[ERROR] %0t: pause_decoder %b, expected %b", $time, pause_decoder,
                         model_full || idle_seen);
            end
            take0 = dispatch_valid[0] && !invalid_en[0] && !pause && !flush && model.size() > 0;
            take1 = take0 && dispatch_valid[1] && !invalid_en[1] && model.size() > 1;
            if (take0) compare_slot(0);
            if (take1) compare_slot(1);
            accepted = !flush && !model_full;
            if (flush) begin
                model.delete();
            end else if (accepted) begin
                for (int s = 0; s < DECODER_WIDTH; s++) begin
                    if (inst_valid[s]) begin  // slot order is program order
                        e.pc              = pc[s];
                        e.uop             = exp_uop[s];
                        e.rd              = exp_rd[s];
                        e.rj              = exp_rj[s];
                        e.rk              = exp_rk[s];
                        e.imm             = exp_imm[s];
                        e.reg_write       = exp_reg_write[s];
                        e.pre_is_branch   = pre_is_branch[s];
                        e.pre_taken       = pre_taken[s];
                        e.pre_branch_addr = pre_branch_addr[s];
                        e.ecode           = exp_ecode[s];
                        model.push_back(e);
                    end
                end
            end
        end
        queue_empty = model.size() == 0;
    end

endmodule

//--- tests/decoder_props.sv
`timescale 1ns/1ps

module decoder_props
    import pipeline_pkg::*;
(
    input logic                   clk,
    input logic                   reset,
    input logic                   flush,
    input logic [ISSUE_WIDTH-1:0] dispatch_valid,
    input logic [1:0]             enq_count,
    input logic                   full,
    input logic                   pause_decoder
);

    int fail_count = 0;

    // queue reads empty right after it is cleared
    a_cleared: assert property (@(posedge clk) (reset || flush) |=> dispatch_valid == '0)
        else begin
            fail_count++;
            $error("dispatch_valid high in the cycle after reset or flush");
        end

    a_in_order: assert property (@(posedge clk) disable iff (reset)
        dispatch_valid[1] |-> dispatch_valid[0])
        else begin
            fail_count++;
            $error("dispatch slot 1 valid without slot 0");
        end

    a_no_write_full: assert property (@(posedge clk) disable iff (reset)
        full |-> enq_count == 2'd0)
        else begin
            fail_count++;
            $error("issue queue written while full");
        end

    a_stall_full: assert property (@(posedge clk) disable iff (reset) full |-> pause_decoder)
        else begin
            fail_count++;
            $error("queue full without pause_decoder");
        end

endmodule

bind decoder decoder_props u_decoder_props (.*);

//--- logic/decoder.sv
`timescale 1ns/1ps

module decoder
    import pipeline_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     flush,
    input  logic                     pause,

    input  logic [DECODER_WIDTH-1:0] inst_valid,
    input  bus32_t                   pc[DECODER_WIDTH],
    input  bus32_t                   inst[DECODER_WIDTH],
    input  logic [DECODER_WIDTH-1:0] pre_is_branch,
    input  logic [DECODER_WIDTH-1:0] pre_taken,
    input  bus32_t                   pre_branch_addr[DECODER_WIDTH],
    input  logic [DECODER_WIDTH-1:0] fetch_exc,
    input  logic [ECODE_WIDTH-1:0]   fetch_ecode[DECODER_WIDTH],

    input  logic [ISSUE_WIDTH-1:0]   invalid_en,

    output logic                     pause_decoder,

    output logic [ISSUE_WIDTH-1:0]   dispatch_valid,
    output bus32_t                   dispatch_pc[ISSUE_WIDTH],
    output logic [UOP_WIDTH-1:0]     dispatch_uop[ISSUE_WIDTH],
    output logic [REG_IDX_WIDTH-1:0] dispatch_rd[ISSUE_WIDTH],
    output logic [REG_IDX_WIDTH-1:0] dispatch_rj[ISSUE_WIDTH],
    output logic [REG_IDX_WIDTH-1:0] dispatch_rk[ISSUE_WIDTH],
    output bus32_t                   dispatch_imm[ISSUE_WIDTH],
    output logic [ISSUE_WIDTH-1:0]   dispatch_reg_write,
    output logic [ISSUE_WIDTH-1:0]   dispatch_pre_is_branch,
    output logic [ISSUE_WIDTH-1:0]   dispatch_pre_taken,
    output bus32_t                   dispatch_pre_branch_addr[ISSUE_WIDTH],
    output logic [ECODE_WIDTH-1:0]   dispatch_ecode[ISSUE_WIDTH]
);

    logic [UOP_WIDTH-1:0]     id_uop[DECODER_WIDTH];
    logic [REG_IDX_WIDTH-1:0] id_rd[DECODER_WIDTH];
    logic [REG_IDX_WIDTH-1:0] id_rj[DECODER_WIDTH];
    logic [REG_IDX_WIDTH-1:0] id_rk[DECODER_WIDTH];
    bus32_t                   id_imm[DECODER_WIDTH];
    logic [DECODER_WIDTH-1:0] id_reg_write;
    logic [ECODE_WIDTH-1:0]   id_ecode[DECODER_WIDTH];
    logic [DECODER_WIDTH-1:0] pause_id;
    logic [ENTRY_WIDTH-1:0]   entry[DECODER_WIDTH];

    logic [1:0]               enq_count;
    logic [ENTRY_WIDTH-1:0]   enq_data[DECODER_WIDTH];
    logic [1:0]               deq_count;
    logic [ENTRY_WIDTH-1:0]   deq_data[ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0]   consume;
    logic                     full;
    logic                     accept;

    generate
        for (genvar i = 0; i < DECODER_WIDTH; i++) begin : gen_slot
            id u_id (
                .inst(inst[i]),
                .fetch_exc(fetch_exc[i]),
                .fetch_ecode(fetch_ecode[i]),
                .uop(id_uop[i]),
                .rd(id_rd[i]),
                .rj(id_rj[i]),
                .rk(id_rk[i]),
                .imm(id_imm[i]),
                .reg_write(id_reg_write[i]),
                .ecode(id_ecode[i]),
                .pause_id(pause_id[i])
            );

            assign entry[i] = {pc[i], id_uop[i], id_rd[i], id_rj[i], id_rk[i], id_imm[i],
                               id_reg_write[i], pre_is_branch[i], pre_taken[i],
                               pre_branch_addr[i], id_ecode[i]};
        end
    endgenerate

    // pack valid slots, slot 1 moves down when slot 0 is empty
    assign accept      = !full && !flush;
    assign enq_count   = accept ? ({1'b0, inst_valid[0]} + {1'b0, inst_valid[1]}) : 2'd0;
    assign enq_data[0] = inst_valid[0] ? entry[0] : entry[1];
    assign enq_data[1] = entry[1];

    issue_queue u_issue_queue (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .enq_count(enq_count),
        .enq_data(enq_data),
        .deq_count(deq_count),
        .deq_valid(dispatch_valid),
        .deq_data(deq_data),
        .full(full)
    );

    // in order: slot 1 only leaves behind slot 0
    assign consume[0] = dispatch_valid[0] && !invalid_en[0] && !pause && !flush;
    assign consume[1] = consume[0] && dispatch_valid[1] && !invalid_en[1];
    assign deq_count  = {1'b0, consume[0]} + {1'b0, consume[1]};

    generate
        for (genvar j = 0; j < ISSUE_WIDTH; j++) begin : gen_out
            assign {dispatch_pc[j], dispatch_uop[j], dispatch_rd[j], dispatch_rj[j],
                    dispatch_rk[j], dispatch_imm[j], dispatch_reg_write[j],
                    dispatch_pre_is_branch[j], dispatch_pre_taken[j],
                    dispatch_pre_branch_addr[j], dispatch_ecode[j]} = deq_data[j];
        end
    endgenerate

    assign pause_decoder = full || |(inst_valid & pause_id);  // idle holds the front end

endmodule

//--- logic/issue_queue.sv
`timescale 1ns/1ps

module issue_queue
    import pipeline_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,

    input  logic [1:0]             enq_count,
    input  logic [ENTRY_WIDTH-1:0] enq_data[DECODER_WIDTH],

    input  logic [1:0]             deq_count,
    output logic [ISSUE_WIDTH-1:0] deq_valid,
    output logic [ENTRY_WIDTH-1:0] deq_data[ISSUE_WIDTH],

    output logic                   full
);

    logic [ENTRY_WIDTH-1:0]     mem[ISSUE_QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] head;
    logic [QUEUE_PTR_WIDTH-1:0] tail;
    logic [QUEUE_CNT_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (enq_count != 2'd0) begin
            mem[tail] <= enq_data[0];
        end
        if (enq_count == 2'd2) begin
            mem[tail + QUEUE_PTR_WIDTH'(1)] <= enq_data[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail + QUEUE_PTR_WIDTH'(enq_count);
            head  <= head + QUEUE_PTR_WIDTH'(deq_count);
            count <= count + QUEUE_CNT_WIDTH'(enq_count) - QUEUE_CNT_WIDTH'(deq_count);
        end
    end

    // first-word fall-through, two oldest entries
    assign deq_data[0]  = mem[head];
    assign deq_data[1]  = mem[head + QUEUE_PTR_WIDTH'(1)];
    assign deq_valid[0] = count != '0;
    assign deq_valid[1] = count > QUEUE_CNT_WIDTH'(1);

    // no room for a whole pair
    assign full = count > QUEUE_CNT_WIDTH'(ISSUE_QUEUE_DEPTH - DECODER_WIDTH);

endmodule

//--- logic/id.sv
`timescale 1ns/1ps

module id
    import pipeline_pkg::*;
    import loongarch_isa_pkg::*;
(
    input  bus32_t                   inst,
    input  logic                     fetch_exc,
    input  logic [ECODE_WIDTH-1:0]   fetch_ecode,

    output logic [UOP_WIDTH-1:0]     uop,
    output logic [REG_IDX_WIDTH-1:0] rd,
    output logic [REG_IDX_WIDTH-1:0] rj,
    output logic [REG_IDX_WIDTH-1:0] rk,
    output bus32_t                   imm,
    output logic                     reg_write,
    output logic [ECODE_WIDTH-1:0]   ecode,
    output logic                     pause_id
);

    inst_word_t  word;
    logic [15:0] offs16;  // branch offset, spans the opcode field
    logic        known;
    logic        wr_en;
    logic        is_sys;
    logic        is_brk;

    assign word   = inst;
    assign offs16 = {word.i.opcode[3:0], word.i.imm12};

    always_comb begin
        uop      = UOP_NOP;
        rd       = word.r.rd;
        rj       = word.r.rj;
        rk       = word.r.rk;
        imm      = '0;
        wr_en    = 1'b0;
        known    = 1'b1;
        is_sys   = 1'b0;
        is_brk   = 1'b0;
        pause_id = 1'b0;
        case (word.r.opcode)
            ADD_W: begin
                uop   = UOP_ALU_ADD;
                wr_en = 1'b1;
            end
            SUB_W: begin
                uop   = UOP_ALU_SUB;
                wr_en = 1'b1;
            end
            SLT: begin
                uop   = UOP_ALU_SLT;
                wr_en = 1'b1;
            end
            AND: begin
                uop   = UOP_ALU_AND;
                wr_en = 1'b1;
            end
            OR: begin
                uop   = UOP_ALU_OR;
                wr_en = 1'b1;
            end
            XOR: begin
                uop   = UOP_ALU_XOR;
                wr_en = 1'b1;
            end
            SYSCALL: begin
                uop    = UOP_SYSCALL;
                is_sys = 1'b1;
            end
            BREAK: begin
                uop    = UOP_BREAK;
                is_brk = 1'b1;
            end
            IDLE: pause_id = 1'b1;  // queued as nop
            default: begin
                rk = '0;
                if (word.i.opcode == ADDI_W) begin
                    uop   = UOP_ALU_ADDI;
                    imm   = {{20{word.i.imm12[11]}}, word.i.imm12};
                    wr_en = 1'b1;
                end else if (word.i.opcode == ANDI) begin
                    uop   = UOP_ALU_ANDI;
                    imm   = {20'b0, word.i.imm12};
                    wr_en = 1'b1;
                end else if (word.i.opcode == ORI) begin
                    uop   = UOP_ALU_ORI;
                    imm   = {20'b0, word.i.imm12};
                    wr_en = 1'b1;
                end else if (word.i.opcode[9:3] == LU12I_W) begin
                    uop   = UOP_ALU_LUI;
                    rj    = '0;  // rj bits belong to si20
                    imm   = {word.i.opcode[2:0], word.i.imm12, word.i.rj, 12'b0};
                    wr_en = 1'b1;
                end else if (word.i.opcode[9:4] == BEQ) begin
                    uop = UOP_BR_EQ;
                    rk  = word.i.rd;  // second compare source
                    imm = {{14{offs16[15]}}, offs16, 2'b00};
                end else if (word.i.opcode[9:4] == BNE) begin
                    uop = UOP_BR_NE;
                    rk  = word.i.rd;
                    imm = {{14{offs16[15]}}, offs16, 2'b00};
                end else begin
                    known = 1'b0;
                    rd    = '0;
                    rj    = '0;
                end
            end
        endcase
        // code field of syscall, break and idle is not a register
        if (is_sys || is_brk || pause_id) begin
            rd = '0;
            rj = '0;
            rk = '0;
        end
    end

    assign reg_write = wr_en && (rd != '0);  // r0 is hardwired

    assign ecode = fetch_exc ? fetch_ecode :
                   !known    ? ECODE_INE   :
                   is_sys    ? ECODE_SYS   :
                   is_brk    ? ECODE_BRK   : ECODE_NONE;

endmodule

//--- logic/loongarch_isa_pkg.sv
package loongarch_isa_pkg;

    // 3R format
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_3r_t;

    // 2RI12 format, also the base for the wider immediate forms
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_2ri12_t;

    typedef union packed {
        inst_3r_t    r;
        inst_2ri12_t i;
    } inst_word_t;

    // inst[31:15]
    localparam logic [16:0] ADD_W   = 17'h00020;
    localparam logic [16:0] SUB_W   = 17'h00022;
    localparam logic [16:0] SLT     = 17'h00024;
    localparam logic [16:0] AND     = 17'h00029;
    localparam logic [16:0] OR      = 17'h0002a;
    localparam logic [16:0] XOR     = 17'h0002b;
    localparam logic [16:0] BREAK   = 17'h00054;
    localparam logic [16:0] SYSCALL = 17'h00056;
    localparam logic [16:0] IDLE    = 17'h00c91;

    // inst[31:22], inst[31:25], inst[31:26]
    localparam logic [9:0] ADDI_W  = 10'h00a;
    localparam logic [9:0] ANDI    = 10'h00d;
    localparam logic [9:0] ORI     = 10'h00e;
    localparam logic [6:0] LU12I_W = 7'h0a;
    localparam logic [5:0] BEQ     = 6'h16;
    localparam logic [5:0] BNE     = 6'h17;

    localparam logic [5:0] UOP_ALU_ADD  = 6'd0;
    localparam logic [5:0] UOP_ALU_SUB  = 6'd1;
    localparam logic [5:0] UOP_ALU_AND  = 6'd2;
    localparam logic [5:0] UOP_ALU_OR   = 6'd3;
    localparam logic [5:0] UOP_ALU_XOR  = 6'd4;
    localparam logic [5:0] UOP_ALU_SLT  = 6'd5;
    localparam logic [5:0] UOP_ALU_ADDI = 6'd6;
    localparam logic [5:0] UOP_ALU_ANDI = 6'd7;
    localparam logic [5:0] UOP_ALU_ORI  = 6'd8;
    localparam logic [5:0] UOP_ALU_LUI  = 6'd9;
    localparam logic [5:0] UOP_BR_EQ    = 6'd10;
    localparam logic [5:0] UOP_BR_NE    = 6'd11;
    localparam logic [5:0] UOP_SYSCALL  = 6'd12;
    localparam logic [5:0] UOP_BREAK    = 6'd13;
    localparam logic [5:0] UOP_NOP      = 6'd14;

    localparam logic [5:0] ECODE_NONE = 6'h00;
    localparam logic [5:0] ECODE_SYS  = 6'h0b;
    localparam logic [5:0] ECODE_BRK  = 6'h0c;
    localparam logic [5:0] ECODE_INE  = 6'h0d;

endpackage

//--- logic/pipeline_pkg.sv
package pipeline_pkg;

    typedef logic [31:0] bus32_t;

    // stage geometry
    localparam int DECODER_WIDTH     = 2;
    localparam int ISSUE_WIDTH       = 2;
    localparam int ISSUE_QUEUE_DEPTH = 8;  // power of two, pointers wrap naturally

    localparam int QUEUE_PTR_WIDTH = $clog2(ISSUE_QUEUE_DEPTH);
    localparam int QUEUE_CNT_WIDTH = $clog2(ISSUE_QUEUE_DEPTH + 1);

    // dispatch entry fields
    localparam int PC_WIDTH      = 32;
    localparam int UOP_WIDTH     = 6;
    localparam int REG_IDX_WIDTH = 5;
    localparam int IMM_WIDTH     = 32;
    localparam int ECODE_WIDTH   = 6;

    localparam int ENTRY_WIDTH = PC_WIDTH        // pc
                               + UOP_WIDTH       // uop
                               + 3 * REG_IDX_WIDTH
                               + IMM_WIDTH
                               + 1               // reg_write
                               + 1               // pre_is_branch
                               + 1               // pre_taken
                               + PC_WIDTH        // pre_branch_addr
                               + ECODE_WIDTH;

endpackage
